// File: testbench/system_stimulus.txt
# One command per line with hex arguments
# W addr data   write a byte
# R addr exp    read and compare with exp
# F page        fill a page with random bytes
# D page        sprite DMA from a page, checked against the model
# U addr        unmapped read, expects the open-bus byte
W 0010 a5
R 0010 a5
W 07ff 3c
R 07ff 3c
W 6000 11
R 6000 11
W 7fff e7
R 7fff e7
W 6abc 42
R 6abc 42
W 0123 5a
R 0123 5a
R 0923 5a
R 1123 5a
R 1923 5a
W 1a00 c3
R 0200 c3
R 0a00 c3
R 6abc 42
U 5000
W 5123 99
U 9000
U 4015
U e000
U 2000
F 03
F 62
D 03
U 8000
D 62
D 0b
D 50
U c000
R 0010 a5
R 07ff 3c
R 0923 5a
R 6000 11
R 7fff e7
W 0400 77
R 1c00 77
W 6300 88
R 6300 88
U a000

// File: filelist.f
source/bus_pkg.sv
source/sys_map_pkg.sv
source/sys_bus_if.sv
source/sync_ram.sv
source/dma_engine.sv
source/mem_arbiter.sv
source/memory_map.sv
source/system.sv
testbench/tb_system.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert --top-module tb_system -f filelist.f -o tb_system
	./obj_dir/tb_system 2>&1 | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: testbench/tb_system.sv
module tb_system;
	import bus_pkg::*;
	import sys_map_pkg::*;

	localparam int WRAM_AW = 11;
	localparam int SRAM_AW = 13;
	localparam int HALF_PERIOD = 10;
	localparam int RESET_CYCLES = 16;
	// CPU stall in cycles after the $4014 write
	localparam int DMA_STALL = 257;

	logic clkCPU2;
	logic n_reset;
	logic cpu_sel;
	logic cpu_rw;
	addr_t cpu_addr;
	data_t cpu_wdata;
	data_t cpu_rdata;
	logic cpu_rdy;
	oam_addr_t oam_addr;
	data_t oam_data;
	logic oam_we;

	// Commands from the stimulus file
	logic [7:0] cmd_q[$];
	addr_t arg_q[$];
	data_t val_q[$];
	bit loaded;

	// Reference model of the memory map
	data_t model_mem [65536];
	data_t model_open;
	logic [31:0] lfsr;

	system #(
		.WRAM_AW(WRAM_AW),
		.SRAM_AW(SRAM_AW)
	) DUT (
		.clkCPU2(clkCPU2), .n_reset(n_reset),
		.cpu_sel(cpu_sel), .cpu_rw(cpu_rw),
		.cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
		.cpu_rdata(cpu_rdata), .cpu_rdy(cpu_rdy),
		.oam_addr(oam_addr), .oam_data(oam_data), .oam_we(oam_we));

	initial begin
		clkCPU2 = 1'b0;
		forever #HALF_PERIOD clkCPU2 = ~clkCPU2;
	end

	// Watchdog sized from the command count
	initial begin
		int limit;
		wait (loaded);
		limit = (cmd_q.size() * 300 + RESET_CYCLES) * 2 * HALF_PERIOD;
		#(limit);
		$display("Watchdog expired after %0d time units, the run hung", limit);
		stop_with_failure();
	end

	task automatic stop_with_failure();
		$display("Some tests failed");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp) begin
			$display("Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_oam_addr(input string name, input oam_addr_t got,
		input oam_addr_t exp);
		if (got !== exp) begin
			$display("Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error at time %0t: %s is %b, expected %b", $time, name, got, exp);
			stop_with_failure();
		end
	endtask

	// Galois form with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	task automatic rand_byte(output data_t b);
		b = '0;
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_step(lfsr);
			b = {b[6:0], lfsr[0]};
		end
	endtask

	function automatic bit is_mapped(input addr_t a);
		return (a & WRAM_MASK) == WRAM_BASE || (a & SRAM_MASK) == SRAM_BASE;
	endfunction

	// Mirrors fold onto the address bits the RAM really has
	function automatic addr_t home_addr(input addr_t a);
		if ((a & WRAM_MASK) == WRAM_BASE)
			return WRAM_BASE | (a & addr_t'((1 << WRAM_AW) - 1));
		return SRAM_BASE | (a & addr_t'((1 << SRAM_AW) - 1));
	endfunction

	function automatic data_t model_read(input addr_t a);
		if (is_mapped(a))
			return model_mem[home_addr(a)];
		return model_open;
	endfunction

	task automatic model_write(input addr_t a, input data_t d);
		if (is_mapped(a))
			model_mem[home_addr(a)] = d;
		model_open = d;
	endtask

	task automatic init_inputs();
		n_reset <= 1'b0;
		cpu_sel <= 1'b0;
		cpu_rw <= 1'b1;
		cpu_addr <= '0;
		cpu_wdata <= '0;
	endtask

	task automatic release_reset();
		repeat (RESET_CYCLES) @(posedge clkCPU2);
		n_reset <= 1'b1;
	endtask

	task automatic cpu_write(input addr_t a, input data_t d);
		@(posedge clkCPU2);
		cpu_sel <= 1'b1;
		cpu_rw <= 1'b0;
		cpu_addr <= a;
		cpu_wdata <= d;
		@(posedge clkCPU2);
		cpu_sel <= 1'b0;
		model_write(a, d);
	endtask

	// Read data is due the cycle after the strobe
	task automatic cpu_read(input addr_t a, output data_t got);
		@(posedge clkCPU2);
		cpu_sel <= 1'b1;
		cpu_rw <= 1'b1;
		cpu_addr <= a;
		@(posedge clkCPU2);
		cpu_sel <= 1'b0;
		@(negedge clkCPU2);
		got = cpu_rdata;
	endtask

	task automatic run_read(input addr_t a, input data_t exp);
		data_t got;
		cpu_read(a, got);
		check_data("cpu_rdata", got, exp);
		if (is_mapped(a))
			model_open = exp;
	endtask

	task automatic fill_page(input page_t p);
		data_t b;
		for (int i = 0; i < 256; i++) begin
			rand_byte(b);
			cpu_write({p, 8'(i)}, b);
		end
	endtask

	task automatic run_dma(input page_t p);
		addr_t a;
		data_t exp;
		@(negedge clkCPU2);
		check_level("cpu_rdy", cpu_rdy, 1'b1);
		cpu_write(DMA_REG, p);
		// Cycle c counts from the write strobe
		for (int c = 1; c <= DMA_STALL + 1; c++) begin
			@(negedge clkCPU2);
			check_level("cpu_rdy", cpu_rdy, c > DMA_STALL);
			check_level("oam_we", oam_we, c >= 2 && c <= DMA_STALL);
			if (oam_we) begin
				a = {p, 8'(c - 2)};
				exp = model_read(a);
				check_oam_addr("oam_addr", oam_addr, oam_addr_t'(c - 2));
				check_data("oam_data", oam_data, exp);
				if (is_mapped(a))
					model_open = exp;
			end
		end
	endtask

	task automatic skip_blank(input int fd, output int c);
		c = $fgetc(fd);
		while (c == 32 || c == 9 || c == 10 || c == 13)
			c = $fgetc(fd);
	endtask

	task automatic load_stimulus();
		int fd;
		int c;
		int n_args;
		int want;
		logic [7:0] cmd;
		addr_t a;
		data_t d;
		fd = $fopen("testbench/system_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Cannot open testbench/system_stimulus.txt");
			stop_with_failure();
		end
		skip_blank(fd, c);
		while (c != -1) begin
			cmd = 8'(c);
			if (cmd == "#") begin
				// Comment runs to the end of the line
				while (c != 10 && c != -1)
					c = $fgetc(fd);
			end else begin
				a = '0;
				d = '0;
				want = (cmd == "W" || cmd == "R") ? 2 : 1;
				n_args = $fscanf(fd, "%h", a);
				if (want == 2 && n_args == 1)
					n_args += $fscanf(fd, "%h", d);
				if (cmd != "W" && cmd != "R" && cmd != "F" && cmd != "D" && cmd != "U") begin
					$display("Unknown command %c in the stimulus file", cmd);
					stop_with_failure();
				end else if (n_args != want) begin
					$display("Command %c in the stimulus file lacks an argument", cmd);
					stop_with_failure();
				end else begin
					cmd_q.push_back(cmd);
					arg_q.push_back(a);
					val_q.push_back(d);
				end
			end
			skip_blank(fd, c);
		end
		$fclose(fd);
	endtask

	task automatic run_command(input logic [7:0] cmd, input addr_t a, input data_t v);
		case (cmd)
		"W": cpu_write(a, v);
		"R":
			if (model_read(a) !== v) begin
				$display("Stimulus expects %h at %h but the model holds %h",
					v, a, model_read(a));
				stop_with_failure();
			end else begin
				run_read(a, v);
			end
		"F": fill_page(a[7:0]);
		"D": run_dma(a[7:0]);
		"U":
			if (is_mapped(a)) begin
				$display("Open-bus read at %h hits a mapped region", a);
				stop_with_failure();
			end else begin
				run_read(a, model_open);
			end
		default: begin
			$display("Command %c cannot be run", cmd);
			stop_with_failure();
		end
		endcase
	endtask

	initial begin
		init_inputs();
		model_open = '0;
		lfsr = 32'h261c;
		loaded = 1'b0;
		load_stimulus();
		loaded = 1'b1;
		release_reset();
		@(negedge clkCPU2);
		check_level("cpu_rdy", cpu_rdy, 1'b1);
		check_level("oam_we", oam_we, 1'b0);
		check_data("cpu_rdata", cpu_rdata, data_t'(0));
		for (int i = 0; i < cmd_q.size(); i++)
			run_command(cmd_q[i], arg_q[i], val_q[i]);
		$display("All tests passed");
		$finish;
	end

endmodule

// File: source/system.sv
module system #(
	parameter int WRAM_AW = 11,
	parameter int SRAM_AW = 13
) (
	input logic clkCPU2,
	input logic n_reset,
	input logic cpu_sel,
	input logic cpu_rw,
	input bus_pkg::addr_t cpu_addr,
	input bus_pkg::data_t cpu_wdata,
	output bus_pkg::data_t cpu_rdata,
	output logic cpu_rdy,
	output bus_pkg::oam_addr_t oam_addr,
	output bus_pkg::data_t oam_data,
	output logic oam_we
);

	sys_bus_if cpu_bus ();
	sys_bus_if dma_bus ();
	sys_bus_if mem_bus ();

	logic dma_busy;

	// External CPU onto its bus
	assign cpu_bus.sel = cpu_sel;
	assign cpu_bus.rw = cpu_rw;
	assign cpu_bus.addr = cpu_addr;
	assign cpu_bus.wdata = cpu_wdata;
	assign cpu_rdata = cpu_bus.rdata;

	// Sprite DMA snoops the CPU bus for $4014
	dma_engine dma0 (
		.clkCPU2(clkCPU2), .n_reset(n_reset),
		.cpu(cpu_bus), .dma(dma_bus), .dma_busy(dma_busy),
		.oam_addr(oam_addr), .oam_data(oam_data), .oam_we(oam_we));

	mem_arbiter arb0 (
		.clkCPU2(clkCPU2), .n_reset(n_reset),
		.cpu(cpu_bus), .dma(dma_bus), .dma_busy(dma_busy),
		.mem(mem_bus), .cpu_rdy(cpu_rdy));

	memory_map #(
		.WRAM_AW(WRAM_AW),
		.SRAM_AW(SRAM_AW)
	) map0 (
		.clkCPU2(clkCPU2), .n_reset(n_reset),
		.bus(mem_bus));

endmodule

// File: source/memory_map.sv
module memory_map #(
	parameter int WRAM_AW = 11,
	parameter int SRAM_AW = 13
) (
	input logic clkCPU2,
	input logic n_reset,
	sys_bus_if.slave bus
);
	import bus_pkg::*;
	import sys_map_pkg::*;

	typedef enum logic [1:0] {REG_NONE, REG_WRAM, REG_SRAM} region_t;

	logic wram_hit;
	logic sram_hit;
	logic wr;
	region_t region;
	region_t region_q;
	data_t wram_q;
	data_t sram_q;
	data_t open_bus;

	// Region decode
	assign wram_hit = (bus.addr & WRAM_MASK) == WRAM_BASE;
	assign sram_hit = (bus.addr & SRAM_MASK) == SRAM_BASE;
	assign wr = bus.sel && !bus.rw;

	always_comb
		if (wram_hit)
			region = REG_WRAM;
		else if (sram_hit)
			region = REG_SRAM;
		else
			region = REG_NONE;

	// Mirroring comes from the unused upper address bits
	sync_ram #(.ADDR_W(WRAM_AW)) wram (
		.clkCPU2(clkCPU2), .n_reset(n_reset),
		.addr(bus.addr[WRAM_AW-1:0]), .wdata(bus.wdata),
		.we(wr && wram_hit), .q(wram_q));

	sync_ram #(.ADDR_W(SRAM_AW)) sram (
		.clkCPU2(clkCPU2), .n_reset(n_reset),
		.addr(bus.addr[SRAM_AW-1:0]), .wdata(bus.wdata),
		.we(wr && sram_hit), .q(sram_q));

	// Region of the read whose data is due this cycle
	always_ff @(posedge clkCPU2, negedge n_reset)
		if (~n_reset)
			region_q <= REG_NONE;
		else if (bus.sel && bus.rw)
			region_q <= region;
		else
			region_q <= REG_NONE;

	always_comb
		case (region_q)
		REG_WRAM: bus.rdata = wram_q;
		REG_SRAM: bus.rdata = sram_q;
		default:  bus.rdata = open_bus;
		endcase

	// Open bus keeps the last byte seen, a write beats returning read data
	always_ff @(posedge clkCPU2, negedge n_reset)
		if (~n_reset)
			open_bus <= '0;
		else if (wr)
			open_bus <= bus.wdata;
		else if (region_q != REG_NONE)
			open_bus <= bus.rdata;

	a_one_region: assert property (@(posedge clkCPU2) disable iff (!n_reset)
		bus.sel |-> $onehot0({wram_hit, sram_hit}))
		else $error("Overlapping memory regions");

endmodule

// File: source/mem_arbiter.sv
module mem_arbiter (
	input logic clkCPU2,
	input logic n_reset,
	sys_bus_if.slave cpu,
	sys_bus_if.slave dma,
	input logic dma_busy,
	sys_bus_if.master mem,
	output logic cpu_rdy
);

	typedef enum logic [1:0] {OWN_NONE, OWN_CPU, OWN_DMA} owner_t;

	// Requester of the read now in flight
	owner_t owner;

	// DMA has priority while busy
	always_comb begin
		if (dma_busy) begin
			mem.sel = dma.sel;
			mem.rw = dma.rw;
			mem.addr = dma.addr;
			mem.wdata = dma.wdata;
		end else begin
			mem.sel = cpu.sel;
			mem.rw = cpu.rw;
			mem.addr = cpu.addr;
			mem.wdata = cpu.wdata;
		end
	end

	always_ff @(posedge clkCPU2, negedge n_reset)
		if (~n_reset)
			owner <= OWN_NONE;
		else if (mem.sel && mem.rw)
			owner <= dma_busy ? OWN_DMA : OWN_CPU;
		else
			owner <= OWN_NONE;

	// Read data only goes back to whoever asked
	assign cpu.rdata = owner == OWN_CPU ? mem.rdata : '0;
	assign dma.rdata = owner == OWN_DMA ? mem.rdata : '0;

	// CPU stalls for the whole transfer
	assign cpu_rdy = ~dma_busy;

	a_cpu_backoff: assert property (@(posedge clkCPU2) disable iff (!n_reset)
		dma_busy |-> !cpu.sel)
		else $error("CPU strobe while stalled by DMA");

	// Grant must not change hands while a read is in flight
	a_owner_known: assert property (@(posedge clkCPU2) disable iff (!n_reset)
		owner != (dma_busy ? OWN_CPU : OWN_DMA))
		else $error("Read owner does not match the bus grant");

endmodule

// File: source/dma_engine.sv
module dma_engine (
	input logic clkCPU2,
	input logic n_reset,
	sys_bus_if.monitor cpu,
	sys_bus_if.master dma,
	output logic dma_busy,
	output bus_pkg::oam_addr_t oam_addr,
	output bus_pkg::data_t oam_data,
	output logic oam_we
);
	import bus_pkg::*;
	import sys_map_pkg::*;

	typedef enum logic [1:0] {IDLE, COPY, DRAIN} state_t;

	state_t state;
	page_t page;
	oam_addr_t idx;
	logic start;

	// CPU write to the DMA register
	assign start = cpu.sel && !cpu.rw && cpu.addr == DMA_REG;

	// Source page, only taken when a transfer starts
	always_ff @(posedge clkCPU2)
		if (state == IDLE && start)
			page <= cpu.wdata;

	always_ff @(posedge clkCPU2, negedge n_reset)
		if (~n_reset) begin
			state <= IDLE;
			idx <= '0;
		end else begin
			case (state)
			IDLE:
				if (start) begin
					state <= COPY;
					idx <= '0;
				end
			COPY: begin
				idx <= idx + 1'b1;
				// Last read of the page goes out this cycle
				if (idx == '1)
					state <= DRAIN;
			end
			// One more cycle to store the final byte
			DRAIN:
				state <= IDLE;
			default:
				state <= IDLE;
			endcase
		end

	// Read issued now, its byte lands in OAM next cycle
	always_ff @(posedge clkCPU2, negedge n_reset)
		if (~n_reset) begin
			oam_we <= 1'b0;
			oam_addr <= '0;
		end else begin
			oam_we <= state == COPY;
			oam_addr <= idx;
		end

	assign oam_data = dma.rdata;
	assign dma_busy = state != IDLE;

	// Read-only master, one byte per cycle
	assign dma.sel = state == COPY;
	assign dma.rw = 1'b1;
	assign dma.addr = {page, idx};
	assign dma.wdata = '0;

	a_oam_we_busy: assert property (@(posedge clkCPU2) disable iff (!n_reset)
		oam_we |-> dma_busy)
		else $error("OAM write outside a DMA transfer");

endmodule

// File: source/sync_ram.sv
module sync_ram #(
	parameter int ADDR_W = 11
) (
	input logic clkCPU2,
	input logic n_reset,
	input logic [ADDR_W-1:0] addr,
	input bus_pkg::data_t wdata,
	input logic we,
	output bus_pkg::data_t q
);
	import bus_pkg::*;

	localparam int DEPTH = 1 << ADDR_W;

	data_t mem [DEPTH];

	// Write port
	always_ff @(posedge clkCPU2)
		if (we)
			mem[addr] <= wdata;

	// Registered read, old data on a same-cycle write
	always_ff @(posedge clkCPU2, negedge n_reset)
		if (~n_reset)
			q <= '0;
		else
			q <= mem[addr];

endmodule

// File: source/sys_bus_if.sv
interface sys_bus_if;
	import bus_pkg::*;

	// Access strobe, one cycle per transfer
	logic sel;
	// High for a read, low for a write
	logic rw;
	addr_t addr;
	data_t wdata;
	// Valid the cycle after a read strobe
	data_t rdata;

	// Requester side
	modport master (output sel, rw, addr, wdata, input rdata);

	// Responder side
	modport slave (input sel, rw, addr, wdata, output rdata);

	// Snooping only
	modport monitor (input sel, rw, addr, wdata, rdata);

endinterface

// File: source/sys_map_pkg.sv
package sys_map_pkg;
	import bus_pkg::*;

	// Region decode is (addr & MASK) == BASE

	// Work RAM, mirrored over $0000 to $1fff
	parameter addr_t WRAM_BASE = 16'h0000;
	parameter addr_t WRAM_MASK = 16'he000;

	// Cartridge SRAM at $6000 to $7fff
	parameter addr_t SRAM_BASE = 16'h6000;
	parameter addr_t SRAM_MASK = 16'he000;

	// A CPU write here starts a sprite DMA from the written page
	parameter addr_t DMA_REG = 16'h4014;

endpackage

// File: source/bus_pkg.sv
package bus_pkg;

	// Widths of the CPU-side system bus

	// Full 16-bit CPU address space
	typedef logic [15:0] addr_t;

	// One data byte on the bus
	typedef logic [7:0] data_t;

	// Source page of a sprite DMA, the upper address byte
	typedef logic [7:0] page_t;

	// Byte index into sprite attribute memory
	typedef logic [7:0] oam_addr_t;

endpackage
